//--- Makefile
VERILATOR = verilator
TOP = fpAddSub_tb
FILELIST = fpAddSub.f
VFLAGS = --binary --assert --timing --timescale 1ns/1ps -Wno-fatal
LINTFLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- fpAddSub.f
+incdir+.
fpFormatPkg.sv
fpStagePkg.sv
fpAddSubAlign.sv
fpAddSubExecute.sv
fpAddSubNormalize.sv
fpAddSubRound.sv
fpAddSub.sv
fpAddSub_properties.sv
fpAddSub_tb.sv

//--- fpAddSub.sv
`include "fpAddSub_macros.svh"

module fpAddSub (
	input  logic clk,
	input  logic rst,
	input  logic inVal,
	input  fpFormatPkg::fp16T a,
	input  fpFormatPkg::fp16T b,
	input  fpFormatPkg::opT op,
	output logic outVal,
	output fpFormatPkg::fp16T result,
	output fpStagePkg::fpFlagsT flags
);
	import fpStagePkg::*;

	alignStageT alignOut;
	execStageT execOut;
	normStageT normOut;

	fpAddSubAlign uAlign (
		.clk(clk),
		.rst(rst),
		.inVal(inVal),
		.a(a),
		.b(b),
		.op(op),
		.stageOut(alignOut)
	);

	fpAddSubExecute uExecute (
		.clk(clk),
		.rst(rst),
		.stageIn(alignOut),
		.stageOut(execOut)
	);

	fpAddSubNormalize uNormalize (
		.clk(clk),
		.rst(rst),
		.stageIn(execOut),
		.stageOut(normOut)
	);

	// Last stage registers the outputs
	fpAddSubRound uRound (
		.clk(clk),
		.rst(rst),
		.stageIn(normOut),
		.outVal(outVal),
		.result(result),
		.flags(flags)
	);

endmodule

//--- fpAddSubAlign.sv
`include "fpAddSub_macros.svh"

module fpAddSubAlign (
	input  logic clk,
	input  logic rst,
	input  logic inVal,
	input  fpFormatPkg::fp16T a,
	input  fpFormatPkg::fp16T b,
	input  fpFormatPkg::opT op,
	output fpStagePkg::alignStageT stageOut
);
	import fpFormatPkg::*;
	import fpStagePkg::*;

	expT expA;
	expT expB;
	expT expMin;
	expT expDiff;
	manT manA;
	manT manB;
	manT manMin;
	logic signA;
	logic signBEff;
	logic zeroA;
	logic zeroB;
	logic infA;
	logic infB;
	logic nanA;
	logic nanB;
	logic bGreater;
	sigT sigMin;
	sigT lostMask;
	alignStageT nxt;

	always_comb begin
		expA = {1'b0, a[`DWIDTH-2 -: `EXPONENT]};
		expB = {1'b0, b[`DWIDTH-2 -: `EXPONENT]};
		manA = a[`MANTISSA-1:0];
		manB = b[`MANTISSA-1:0];
		signA = a[`DWIDTH-1];
		signBEff = b[`DWIDTH-1] ^ (op == OP_SUB);	// Sign of b as it is applied
		zeroA = (expA == '0);			// Subnormals flushed too
		zeroB = (expB == '0);
		infA = (expA == `EXP_INF) && (manA == '0);
		infB = (expB == `EXP_INF) && (manB == '0);
		nanA = (expA == `EXP_INF) && (manA != '0);
		nanB = (expB == `EXP_INF) && (manB != '0);

		// Order by magnitude
		bGreater = b[`DWIDTH-2:0] > a[`DWIDTH-2:0];
		nxt.maxAB = bGreater;
		nxt.manMax = bGreater ? manB : manA;
		nxt.expMax = bGreater ? expB : expA;
		nxt.signMax = bGreater ? b[`DWIDTH-1] : signA;
		nxt.signMin = bGreater ? signA : b[`DWIDTH-1];
		manMin = bGreater ? manA : manB;
		expMin = bGreater ? expA : expB;
		expDiff = nxt.expMax - expMin;

		// Shift right, fold lost bits into the lowest guard bit
		sigMin = {1'b1, manMin, {`GUARDBITS{1'b0}}};
		lostMask = ~(sigT'('1) << expDiff);
		nxt.sigMin = (sigMin >> expDiff) | sigT'(|(sigMin & lostMask));

		nxt.valid = inVal;
		nxt.op = op;
		nxt.special = 1'b1;
		nxt.specialFlags = '0;
		if (nanA || nanB || (infA && infB && (signA != signBEff))) begin
			nxt.specialVal = `CANON_NAN;
			nxt.specialFlags.invalid = 1'b1;
		end else if (infA) begin
			nxt.specialVal = a;
		end else if (infB) begin
			nxt.specialVal = {signBEff, b[`DWIDTH-2:0]};
		end else if (zeroA && zeroB) begin
			nxt.specialVal = {signA & signBEff, {(`DWIDTH-1){1'b0}}};	// -0 only if both negative
		end else if (zeroA) begin
			nxt.specialVal = {signBEff, b[`DWIDTH-2:0]};
		end else if (zeroB) begin
			nxt.specialVal = a;
		end else begin
			nxt.special = 1'b0;
			nxt.specialVal = '0;
		end
	end

	always_ff @(posedge clk) begin
		stageOut <= nxt;
		if (rst)
			stageOut.valid <= 1'b0;
	end

endmodule

//--- fpAddSubExecute.sv
`include "fpAddSub_macros.svh"

module fpAddSubExecute (
	input  logic clk,
	input  logic rst,
	input  fpStagePkg::alignStageT stageIn,
	output fpStagePkg::execStageT stageOut
);
	import fpFormatPkg::*;
	import fpStagePkg::*;

	sumT sigMax;
	sumT sigMinExt;
	logic isSub;
	execStageT nxt;

	always_comb begin
		isSub = (stageIn.op == OP_SUB);
		sigMax = {2'b01, stageIn.manMax, {`GUARDBITS{1'b0}}};	// Restore hidden bit
		sigMinExt = {1'b0, stageIn.sigMin};

		// Effective operation from op and both signs
		nxt.effSub = isSub ^ stageIn.signMax ^ stageIn.signMin;
		nxt.sum = nxt.effSub ? (sigMax - sigMinExt) : (sigMax + sigMinExt);

		// Larger operand decides the sign
		nxt.sign = stageIn.maxAB ? (stageIn.signMax ^ isSub) : stageIn.signMax;

		nxt.valid = stageIn.valid;
		nxt.exp = stageIn.expMax;
		nxt.special = stageIn.special;
		nxt.specialVal = stageIn.specialVal;
		nxt.specialFlags = stageIn.specialFlags;
	end

	always_ff @(posedge clk) begin
		stageOut <= nxt;
		if (rst)
			stageOut.valid <= 1'b0;
	end

endmodule

//--- fpAddSubNormalize.sv
`include "fpAddSub_macros.svh"

module fpAddSubNormalize (
	input  logic clk,
	input  logic rst,
	input  fpStagePkg::execStageT stageIn,
	output fpStagePkg::normStageT stageOut
);
	import fpFormatPkg::*;
	import fpStagePkg::*;

	// Leading zeros of the significand, full width if all zero
	function automatic logic [4:0] leadZeros(input sigT s);
		logic [4:0] n;
		logic found;
		n = 5'($bits(sigT));
		found = 1'b0;
		for (int i = $bits(sigT) - 1; i >= 0; i--) begin
			if (!found && s[i]) begin
				n = 5'($bits(sigT) - 1 - i);
				found = 1'b1;
			end
		end
		return n;
	endfunction

	sigT low;
	logic [4:0] lz;
	normStageT nxt;

	always_comb begin
		low = stageIn.sum[`MANTISSA+`GUARDBITS:0];	// Sum without carry
		lz = leadZeros(low);

		if (stageIn.sum[`DWIDTH]) begin
			// Carry out, shift right once
			nxt.sig = stageIn.sum[`DWIDTH:1];
			nxt.sticky = stageIn.sum[0];
			nxt.exp = stageIn.exp + 1'b1;
			nxt.tiny = 1'b0;
		end else begin
			nxt.sig = low << lz;
			nxt.sticky = 1'b0;
			nxt.exp = stageIn.exp - expT'(lz);
			nxt.tiny = expT'(lz) >= stageIn.exp;	// Biased exponent would reach 0 or less
		end

		// Only cancellation can give an all-zero sum
		nxt.zero = stageIn.effSub && (low == '0);

		nxt.valid = stageIn.valid;
		nxt.sign = stageIn.sign;
		nxt.special = stageIn.special;
		nxt.specialVal = stageIn.specialVal;
		nxt.specialFlags = stageIn.specialFlags;
	end

	always_ff @(posedge clk) begin
		stageOut <= nxt;
		if (rst)
			stageOut.valid <= 1'b0;
	end

endmodule

//--- fpAddSubRound.sv
`include "fpAddSub_macros.svh"

module fpAddSubRound (
	input  logic clk,
	input  logic rst,
	input  fpStagePkg::normStageT stageIn,
	output logic outVal,
	output fpFormatPkg::fp16T result,
	output fpStagePkg::fpFlagsT flags
);
	import fpFormatPkg::*;
	import fpStagePkg::*;

	logic guard;
	logic stickyAll;
	logic roundUp;
	logic [`MANTISSA+1:0] rounded;		// Carry, hidden bit, fraction
	expT expFinal;
	fp16T resNext;
	fpFlagsT flagsNext;

	always_comb begin
		guard = stageIn.sig[`GUARDBITS-1];
		stickyAll = stageIn.sticky | (|stageIn.sig[`GUARDBITS-2:0]);
		roundUp = guard & (stickyAll | stageIn.sig[`GUARDBITS]);	// Ties go to even
		rounded = {1'b0, stageIn.sig[`MANTISSA+`GUARDBITS:`GUARDBITS]} + roundUp;
		expFinal = stageIn.exp + rounded[`MANTISSA+1];	// Renormalize on carry

		flagsNext = '0;
		if (stageIn.special) begin
			resNext = stageIn.specialVal;
			flagsNext = stageIn.specialFlags;
		end else if (stageIn.zero) begin
			resNext = '0;			// Exact cancellation is +0
		end else if (stageIn.tiny) begin
			resNext = {stageIn.sign, {(`DWIDTH-1){1'b0}}};
			flagsNext.underflow = 1'b1;
		end else if (expFinal >= `EXP_INF) begin
			resNext = {stageIn.sign, {`EXPONENT{1'b1}}, {`MANTISSA{1'b0}}};
			flagsNext.overflow = 1'b1;
		end else begin
			// Fraction bits are already zero after a rounding carry
			resNext = {stageIn.sign, expFinal[`EXPONENT-1:0], rounded[`MANTISSA-1:0]};
		end
	end

	always_ff @(posedge clk) begin
		outVal <= stageIn.valid;
		result <= resNext;
		flags <= flagsNext;
		if (rst)
			outVal <= 1'b0;
	end

endmodule

//--- fpAddSub_input.txt
# Columns: name a b op(0 add, 1 sub) expected_result expected_flags
# Values in hex, flags in binary as invalid overflow underflow
addExact    3C00 3C00 0 4000 000
addThree    3C00 4000 0 4200 000
tieEven     3C00 1000 0 3C00 000
tieUp       3C01 1000 0 3C02 000
roundUp     3C00 1200 0 3C01 000
carryExp    3E00 3E00 0 4200 000
roundCarry  3FFF 1000 0 4000 000
mixedSign   4200 BC00 0 4000 000
subSwap     3C00 4200 1 C000 000
cancelLong  3C01 3C00 1 1400 000
cancelExact BE00 3E00 0 0000 000
overflowPos 7BFF 7BFF 0 7C00 010
overflowNeg FBFF FBFF 0 FC00 010
underPos    0600 0400 1 0000 001
underNeg    0400 0600 1 8000 001
subnormIn   3C00 0001 0 3C00 000
subnormBoth 0200 0300 0 0000 000
nanIn       7C01 3C00 0 7E00 100
infMinusInf 7C00 7C00 1 7E00 100
infPlusFin  7C00 3C00 0 7C00 000
finMinusInf 3C00 7C00 1 FC00 000

//--- fpAddSub_macros.svh
`ifndef FPADDSUB_MACROS_SVH
`define FPADDSUB_MACROS_SVH

// binary16 field widths
`define SIGN 1
`define EXPONENT 5
`define MANTISSA 10
`define DWIDTH (`SIGN+`EXPONENT+`MANTISSA)

`define BIAS 15

// All-ones exponent, marks infinity and NaN
`define EXP_INF (2*`BIAS+1)

// Zero bits appended below the fraction while adding
`define GUARDBITS 5

// Quiet NaN returned for every invalid case
`define CANON_NAN 16'h7E00

`endif

//--- fpAddSub_properties.sv
`include "fpAddSub_macros.svh"

module fpAddSub_properties (
	input logic clk,
	input logic rst,
	input logic inVal,
	input logic outVal,
	input fpFormatPkg::fp16T result,
	input fpStagePkg::fpFlagsT flags
);
	timeunit 1ns;
	timeprecision 1ps;

	// Fixed pipeline depth of four
	latencyFixed: assert property (@(posedge clk) disable iff (rst)
		outVal == $past(inVal, 4))
		else $error("outVal does not follow inVal by four cycles");

	resetQuiet: assert property (@(posedge clk) rst |=> !outVal)
		else $error("outVal high during reset");

	releaseQuiet: assert property (@(posedge clk) $fell(rst) |=> !outVal)
		else $error("outVal high in the cycle after reset");

	// Every invalid result is the canonical NaN
	invalidNan: assert property (@(posedge clk) disable iff (rst)
		(outVal && flags.invalid) |-> (result == `CANON_NAN))
		else $error("invalid flag set without canonical NaN result");

endmodule

//--- fpAddSub_tb.sv
module fpAddSub_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import fpFormatPkg::*;
	import fpStagePkg::*;

	localparam int MAXVEC = 64;
	localparam int LATENCY = 4;
	localparam int MARGIN = 20;

	logic clk;
	logic rst;
	logic inVal;
	fp16T a;
	fp16T b;
	opT op;
	logic outVal;
	fp16T result;
	fpFlagsT flags;

	string nameArr [MAXVEC];
	fp16T aArr [MAXVEC];
	fp16T bArr [MAXVEC];
	opT opArr [MAXVEC];
	fp16T resArr [MAXVEC];
	fpFlagsT flagArr [MAXVEC];
	int numVectors;
	int expQ [$];			// Vector indices still in flight
	int outIdx;
	int checkedCount;
	int resultErrors;
	int flagErrors;
	int protocolErrors;
	int cycleCount;
	int cycleLimit;
	logic running;

	fpAddSub DUT (
		.clk(clk),
		.rst(rst),
		.inVal(inVal),
		.a(a),
		.b(b),
		.op(op),
		.outVal(outVal),
		.result(result),
		.flags(flags)
	);

	bind fpAddSub fpAddSub_properties uProps (
		.clk(clk),
		.rst(rst),
		.inVal(inVal),
		.outVal(outVal),
		.result(result),
		.flags(flags)
	);

	always #4 clk = ~clk;		// 8 ns period

	task automatic loadVectors();
		int fd;
		int fields;
		int opVal;
		string line;
		string tag;
		fp16T aVal;
		fp16T bVal;
		fp16T resVal;
		logic [2:0] flagVal;
		fd = $fopen("fpAddSub_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file fpAddSub_input.txt");
			protocolErrors++;
		end else begin
			while (!$feof(fd) && numVectors < MAXVEC) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#") begin	// Skip comments and blanks
					fields = $sscanf(line, "%s %h %h %d %h %b",
						tag, aVal, bVal, opVal, resVal, flagVal);
					if (fields == 6) begin
						nameArr[numVectors] = tag;
						aArr[numVectors] = aVal;
						bArr[numVectors] = bVal;
						opArr[numVectors] = opT'(opVal[0]);
						resArr[numVectors] = resVal;
						flagArr[numVectors] = fpFlagsT'(flagVal);
						numVectors++;
					end
				end
			end
			$fclose(fd);
		end
		if (numVectors == 0) begin
			$display("No stimulus vectors were read");
			protocolErrors++;
		end
	endtask

	task automatic checkResult(input string tag, input fp16T expected, input fp16T actual);
		if (actual !== expected) begin
			resultErrors++;
			$display("Fail %s result: expected %h, actual %h", tag, expected, actual);
		end
	endtask

	task automatic checkFlags(input string tag, input fpFlagsT expected, input fpFlagsT actual);
		if (actual !== expected) begin
			flagErrors++;
			$display("Fail %s flags: expected %b, actual %b", tag, expected, actual);
		end
	endtask

	// Results are compared in issue order
	always @(posedge clk) begin
		if (!rst && outVal) begin
			if (expQ.size() == 0) begin
				$display("outVal went high with no operation in flight");
				protocolErrors++;
			end else begin
				outIdx = expQ.pop_front();
				checkResult(nameArr[outIdx], resArr[outIdx], result);
				checkFlags(nameArr[outIdx], flagArr[outIdx], flags);
				checkedCount++;
			end
		end
	end

	always @(posedge clk) begin
		if (running) begin
			cycleCount++;
			if (cycleCount > cycleLimit) begin
				$display("Timeout after %0d cycles with %0d results missing",
					cycleCount, numVectors - checkedCount);
				$display("TEST FAILED");
				$finish;
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		inVal = 1'b0;
		a = '0;
		b = '0;
		op = OP_ADD;
		running = 1'b0;
		numVectors = 0;
		checkedCount = 0;
		resultErrors = 0;
		flagErrors = 0;
		protocolErrors = 0;
		cycleCount = 0;
		loadVectors();
		cycleLimit = numVectors + LATENCY + MARGIN;

		repeat (4) @(posedge clk);
		rst <= 1'b0;
		running <= 1'b1;
		for (int i = 0; i < numVectors; i++) begin
			@(posedge clk);
			inVal <= 1'b1;			// Back to back with no gaps
			a <= aArr[i];
			b <= bArr[i];
			op <= opArr[i];
			expQ.push_back(i);
		end
		@(posedge clk);
		inVal <= 1'b0;

		while (checkedCount < numVectors) begin
			@(posedge clk);
		end
		repeat (LATENCY + 2) @(posedge clk);	// Window for a stray outVal

		$display("Errors: result %0d, flags %0d, protocol %0d",
			resultErrors, flagErrors, protocolErrors);
		if (resultErrors + flagErrors + protocolErrors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- fpFormatPkg.sv
`include "fpAddSub_macros.svh"

package fpFormatPkg;

	// Packed operand or result word
	typedef logic [`DWIDTH-1:0] fp16T;

	// Biased exponent, one spare bit to see overflow
	typedef logic [`EXPONENT:0] expT;

	// Stored fraction
	typedef logic [`MANTISSA-1:0] manT;

	// Hidden bit, fraction and guard bits
	typedef logic [`MANTISSA+`GUARDBITS:0] sigT;

	// Execute result with carry on top
	typedef logic [`DWIDTH:0] sumT;

	typedef enum logic {
		OP_ADD = 1'b0,
		OP_SUB = 1'b1
	} opT;

endpackage

//--- fpStagePkg.sv
package fpStagePkg;

	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
	} fpFlagsT;

	typedef struct packed {
		logic valid;
		fpFormatPkg::manT manMax;		// Fraction of larger operand
		fpFormatPkg::sigT sigMin;		// Aligned smaller significand, sticky in bit 0
		logic signMax;
		logic signMin;
		logic maxAB;				// Larger operand is b
		fpFormatPkg::opT op;
		fpFormatPkg::expT expMax;
		logic special;
		fpFormatPkg::fp16T specialVal;
		fpFlagsT specialFlags;
	} alignStageT;

	typedef struct packed {
		logic valid;
		fpFormatPkg::sumT sum;
		logic sign;
		logic effSub;
		fpFormatPkg::expT exp;
		logic special;
		fpFormatPkg::fp16T specialVal;
		fpFlagsT specialFlags;
	} execStageT;

	typedef struct packed {
		logic valid;
		fpFormatPkg::sigT sig;			// Hidden bit at the top
		logic sticky;
		logic sign;
		fpFormatPkg::expT exp;
		logic zero;
		logic tiny;				// Exponent fell below one
		logic special;
		fpFormatPkg::fp16T specialVal;
		fpFlagsT specialFlags;
	} normStageT;

endpackage
